// ==== include/wb_consts.svh ====
// Writeback back end constants
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// Datapath width in bits
`define WB_XLEN 32

// Instruction IDs in flight, power of two
`define WB_MAX_INFLIGHT 4

// Execution units reporting to writeback
`define WB_NUM_UNITS 2

// Architectural integer registers
`define WB_NUM_REGS 16

`endif

// ==== src/commit_pkg.sv ====
// Commit tracking types
`default_nettype none
`include "wb_consts.svh"

package commit_pkg;

    // Tag for one in-flight instruction
    typedef logic [$clog2(`WB_MAX_INFLIGHT)-1:0] instr_id_t;

    // Architectural register index
    typedef logic [$clog2(`WB_NUM_REGS)-1:0] reg_addr_t;

    // Per-ID metadata kept until retire
    typedef struct packed {
        reg_addr_t rd_addr;
    } inflight_packet_t;

    // Completion record from one unit
    typedef struct packed {
        logic done;
        instr_id_t id;
        logic [`WB_XLEN-1:0] result;
    } unit_wb_t;

endpackage

`default_nettype wire

// ==== src/exec_pkg.sv ====
// Execution types
`default_nettype none
`include "wb_consts.svh"

package exec_pkg;

    // Integer opcodes
    typedef enum logic [2:0] {
        op_add, op_sub, op_xor, op_and, op_sll, op_srl
    } exec_op_t;

    // Unit index, also indexes the writeback record array
    typedef enum logic [$clog2(`WB_NUM_UNITS)-1:0] {
        unit_alu, unit_shift
    } unit_sel_t;

    // Bit-serial shifter states
    typedef enum logic [0:0] {
        st_idle, st_shift
    } shift_state_t;

endpackage

`default_nettype wire

// ==== src/wb_ifs.sv ====
// Issue tracking and commit interfaces
`timescale 1ns/10ps
`default_nettype none
`include "wb_consts.svh"

//////////////////////////////////////////////////////////////////////
// Issue side between scoreboard and writeback
interface tracking_if;
    logic issued;
    exec_pkg::unit_sel_t issue_unit;
    commit_pkg::inflight_packet_t issue_packet;
    // Returned by the ID tracker
    commit_pkg::instr_id_t issue_id;
    logic id_available;

    modport scoreboard (
        output issued, issue_unit, issue_packet,
        input issue_id, id_available
    );
    modport wb (
        input issued, issue_unit, issue_packet,
        output issue_id, id_available
    );
endinterface

//////////////////////////////////////////////////////////////////////
// Register file commit and operand bypass
interface rf_commit_if;
    // Retire port
    logic retiring;
    commit_pkg::instr_id_t retire_id;
    commit_pkg::reg_addr_t rd_addr;
    logic rd_nzero;
    logic [`WB_XLEN-1:0] rd_data;
    // Bypass lookup by writer ID
    commit_pkg::instr_id_t rs1_id;
    commit_pkg::instr_id_t rs2_id;
    logic rs1_valid;
    logic [`WB_XLEN-1:0] rs1_data;
    logic rs2_valid;
    logic [`WB_XLEN-1:0] rs2_data;

    modport scoreboard (
        input retiring, retire_id, rd_addr, rd_nzero, rd_data,
        output rs1_id, rs2_id,
        input rs1_valid, rs1_data, rs2_valid, rs2_data
    );
    modport wb (
        output retiring, retire_id, rd_addr, rd_nzero, rd_data,
        input rs1_id, rs2_id,
        output rs1_valid, rs1_data, rs2_valid, rs2_data
    );
endinterface

`default_nettype wire

// ==== src/id_tracker.sv ====
// Instruction ID tracker
`timescale 1ns/10ps
`default_nettype none
`include "wb_consts.svh"

module id_tracker (
    input logic clk,
    input logic rst,
    input logic issued,
    input logic retired,
    output commit_pkg::instr_id_t next_id,
    output commit_pkg::instr_id_t oldest_id,
    output logic id_available,
    output logic empty
);
    localparam int CNT_W = $clog2(`WB_MAX_INFLIGHT) + 1;
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(`WB_MAX_INFLIGHT);

    // One extra bit so full and empty differ
    logic [CNT_W-1:0] inflight_count;

    //////////////////////////////////////////////////////////////////////
    // Wrapping pointers, allocate at issue and free at retire
    always_ff @(posedge clk) begin
        if (rst) begin
            next_id <= '0;
            oldest_id <= '0;
            inflight_count <= '0;
        end else begin
            if (issued)
                next_id <= next_id + 1'b1;
            if (retired)
                oldest_id <= oldest_id + 1'b1;
            // Count moves only when one side acts alone
            case ({issued, retired})
                2'b10: inflight_count <= inflight_count + 1'b1;
                2'b01: inflight_count <= inflight_count - 1'b1;
                default: inflight_count <= inflight_count;
            endcase
        end
    end

    // Flags straight from occupancy
    assign id_available = (inflight_count != FULL_COUNT);
    assign empty = (inflight_count == '0);

endmodule

`default_nettype wire

// ==== src/write_back.sv ====
// Writeback and in-order commit
`timescale 1ns/10ps
`default_nettype none
`include "wb_consts.svh"

module write_back (
    input logic clk,
    input logic rst,
    input commit_pkg::unit_wb_t unit_wb [`WB_NUM_UNITS-1:0],
    tracking_if.wb ti,
    rf_commit_if.wb rf,
    output logic queue_empty
);
    localparam int NUM_IDS = `WB_MAX_INFLIGHT;

    // Destination per ID
    commit_pkg::inflight_packet_t id_metadata [NUM_IDS-1:0];
    commit_pkg::inflight_packet_t retiring_packet;
    // Unit that owns each ID
    exec_pkg::unit_sel_t id_unit_select_r [NUM_IDS-1:0];
    exec_pkg::unit_sel_t id_unit_select [NUM_IDS-1:0];
    // Commit buffer
    logic [`WB_XLEN-1:0] results_by_id [NUM_IDS-1:0];

    logic [NUM_IDS-1:0] id_inuse;
    logic [NUM_IDS-1:0] id_issued_oh;
    logic [NUM_IDS-1:0] id_writing;
    logic [NUM_IDS-1:0] id_pending;
    logic [NUM_IDS-1:0] id_pending_r;
    logic [NUM_IDS-1:0] id_retiring_oh;

    commit_pkg::instr_id_t oldest_id;
    commit_pkg::instr_id_t id_retiring;
    logic retiring_next;
    logic retiring;

    genvar g;

    //////////////////////////////////////////////////////////////////////
    // Per-ID done decode
    // Any unit reporting the ID marks it written this cycle
    always_comb begin
        id_writing = '0;
        for (int i = 0; i < NUM_IDS; i++) begin
            for (int j = 0; j < `WB_NUM_UNITS; j++) begin
                id_writing[i] = id_writing[i] |
                    (unit_wb[j].done && (unit_wb[j].id == commit_pkg::instr_id_t'(i)));
            end
        end
    end

    // Issue strobe as one-hot on the new ID
    always_comb begin
        id_issued_oh = '0;
        id_issued_oh[ti.issue_id] = ti.issued;
    end

    //////////////////////////////////////////////////////////////////////
    // Unit select and commit buffer
    generate
        for (g = 0; g < NUM_IDS; g++) begin : gen_id_slot
            always_ff @(posedge clk) begin
                if (id_issued_oh[g])
                    id_unit_select_r[g] <= ti.issue_unit;
            end
            // Unused IDs follow the current issue for single-cycle units
            assign id_unit_select[g] = id_inuse[g] ? id_unit_select_r[g] : ti.issue_unit;

            always_ff @(posedge clk) begin
                if (id_writing[g])
                    results_by_id[g] <= unit_wb[id_unit_select[g]].result;
            end
        end
    endgenerate

    // In use from issue until the result lands
    always_ff @(posedge clk) begin
        if (rst)
            id_inuse <= '0;
        else
            id_inuse <= (id_inuse | id_issued_oh) & ~id_writing;
    end

    //////////////////////////////////////////////////////////////////////
    // ID ordering
    id_tracker id_tracker0 (
        .clk(clk),
        .rst(rst),
        .issued(ti.issued),
        .retired(retiring_next),
        .next_id(ti.issue_id),
        .oldest_id(oldest_id),
        .id_available(ti.id_available),
        .empty(queue_empty)
    );

    // Metadata table, written on the issue edge
    always_ff @(posedge clk) begin
        if (ti.issued)
            id_metadata[ti.issue_id] <= ti.issue_packet;
    end
    assign retiring_packet = id_metadata[id_retiring];

    //////////////////////////////////////////////////////////////////////
    // Retire logic
    // Pending from buffer write until the retire cycle ends
    always_ff @(posedge clk) begin
        if (rst)
            id_pending_r <= '0;
        else
            id_pending_r <= id_pending;
    end
    assign id_pending = id_writing | (id_pending_r & ~id_retiring_oh);

    // Oldest one ready goes next
    assign retiring_next = id_pending[oldest_id];

    always_ff @(posedge clk) begin
        if (rst)
            retiring <= 1'b0;
        else
            retiring <= retiring_next;
    end

    always_ff @(posedge clk) begin
        id_retiring <= oldest_id;
    end

    always_comb begin
        id_retiring_oh = '0;
        id_retiring_oh[id_retiring] = retiring;
    end

    // Commit port
    assign rf.retiring = retiring;
    assign rf.retire_id = id_retiring;
    assign rf.rd_addr = retiring_packet.rd_addr;
    assign rf.rd_nzero = |retiring_packet.rd_addr;
    assign rf.rd_data = results_by_id[id_retiring];

    // Operand bypass, still valid during the retire cycle
    assign rf.rs1_valid = id_pending_r[rf.rs1_id];
    assign rf.rs2_valid = id_pending_r[rf.rs2_id];
    assign rf.rs1_data = results_by_id[rf.rs1_id];
    assign rf.rs2_data = results_by_id[rf.rs2_id];

endmodule

`default_nettype wire

// ==== src/alu_unit.sv ====
// Single-cycle ALU
`timescale 1ns/10ps
`default_nettype none
`include "wb_consts.svh"

module alu_unit (
    input logic clk,
    input logic rst,
    input logic start,
    input exec_pkg::exec_op_t op,
    input logic [`WB_XLEN-1:0] a,
    input logic [`WB_XLEN-1:0] b,
    input commit_pkg::instr_id_t id,
    output commit_pkg::unit_wb_t wb
);
    logic done_r;
    commit_pkg::instr_id_t id_r;
    logic [`WB_XLEN-1:0] result_r;

    // Done follows start by one edge
    always_ff @(posedge clk) begin
        if (rst)
            done_r <= 1'b0;
        else
            done_r <= start;
    end

    always_ff @(posedge clk) begin
        if (start) begin
            id_r <= id;
            case (op)
                exec_pkg::op_add: result_r <= a + b;
                exec_pkg::op_sub: result_r <= a - b;
                exec_pkg::op_xor: result_r <= a ^ b;
                exec_pkg::op_and: result_r <= a & b;
                // Shifts never routed here
                default: result_r <= a;
            endcase
        end
    end

    assign wb.done = done_r;
    assign wb.id = id_r;
    assign wb.result = result_r;

endmodule

`default_nettype wire

// ==== src/shift_unit.sv ====
// Bit-serial logical shifter
`timescale 1ns/10ps
`default_nettype none
`include "wb_consts.svh"

module shift_unit (
    input logic clk,
    input logic rst,
    input logic start,
    input exec_pkg::exec_op_t op,
    input logic [`WB_XLEN-1:0] a,
    input logic [`WB_XLEN-1:0] b,
    input commit_pkg::instr_id_t id,
    output logic busy,
    output commit_pkg::unit_wb_t wb
);
    localparam int SHAMT_W = $clog2(`WB_XLEN);

    exec_pkg::shift_state_t state;
    logic done_r;
    // Working operand and bits left to go
    logic [`WB_XLEN-1:0] shift_val;
    logic [SHAMT_W-1:0] count;
    exec_pkg::exec_op_t op_r;
    commit_pkg::instr_id_t id_r;

    //////////////////////////////////////////////////////////////////////
    // Control FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= exec_pkg::st_idle;
            done_r <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state)
                exec_pkg::st_idle: begin
                    if (start)
                        state <= exec_pkg::st_shift;
                end
                exec_pkg::st_shift: begin
                    // Count hits zero, result is final
                    if (count == '0) begin
                        done_r <= 1'b1;
                        state <= exec_pkg::st_idle;
                    end
                end
                default: state <= exec_pkg::st_idle;
            endcase
        end
    end

    // Datapath, one bit per cycle
    always_ff @(posedge clk) begin
        if (state == exec_pkg::st_idle && start) begin
            shift_val <= a;
            count <= b[SHAMT_W-1:0];
            op_r <= op;
            id_r <= id;
        end else if (state == exec_pkg::st_shift && count != '0) begin
            count <= count - 1'b1;
            if (op_r == exec_pkg::op_sll)
                shift_val <= shift_val << 1;
            else
                shift_val <= shift_val >> 1;
        end
    end

    assign busy = (state == exec_pkg::st_shift);

    assign wb.done = done_r;
    assign wb.id = id_r;
    assign wb.result = shift_val;

endmodule

`default_nettype wire

// ==== src/reg_scoreboard.sv ====
// Register file and issue scoreboard
`timescale 1ns/10ps
`default_nettype none
`include "wb_consts.svh"

module reg_scoreboard (
    input logic clk,
    input logic rst,
    input logic issue_valid,
    input exec_pkg::exec_op_t issue_op,
    input commit_pkg::reg_addr_t issue_rd,
    input commit_pkg::reg_addr_t issue_rs1,
    input commit_pkg::reg_addr_t issue_rs2,
    output logic issue_ready,
    input logic shift_busy,
    output logic [`WB_NUM_UNITS-1:0] unit_start,
    output exec_pkg::exec_op_t unit_op,
    output logic [`WB_XLEN-1:0] unit_a,
    output logic [`WB_XLEN-1:0] unit_b,
    output commit_pkg::instr_id_t unit_id,
    tracking_if.scoreboard ti,
    rf_commit_if.scoreboard rf
);
    logic [`WB_XLEN-1:0] regs [`WB_NUM_REGS-1:0];
    logic [`WB_NUM_REGS-1:0] reg_pending;
    // Latest writer per register
    commit_pkg::instr_id_t reg_writer [`WB_NUM_REGS-1:0];

    exec_pkg::unit_sel_t sel_unit;
    logic rs1_ok;
    logic rs2_ok;
    logic unit_ok;
    logic accept;
    logic issue_en;

    //////////////////////////////////////////////////////////////////////
    // Issue decision
    assign sel_unit = (issue_op == exec_pkg::op_sll || issue_op == exec_pkg::op_srl) ?
                      exec_pkg::unit_shift : exec_pkg::unit_alu;

    // Bypass lookup by latest writer
    assign rf.rs1_id = reg_writer[issue_rs1];
    assign rf.rs2_id = reg_writer[issue_rs2];

    // Committed, or result already in the commit buffer
    assign rs1_ok = !reg_pending[issue_rs1] || rf.rs1_valid;
    assign rs2_ok = !reg_pending[issue_rs2] || rf.rs2_valid;
    assign unit_ok = !(sel_unit == exec_pkg::unit_shift && shift_busy);

    assign issue_ready = issue_en && ti.id_available && rs1_ok && rs2_ok && unit_ok;
    assign accept = issue_valid && issue_ready;

    assign ti.issued = accept;
    assign ti.issue_unit = sel_unit;
    assign ti.issue_packet = commit_pkg::inflight_packet_t'{rd_addr: issue_rd};

    // Start pulse to the chosen unit only
    always_comb begin
        unit_start = '0;
        unit_start[sel_unit] = accept;
    end

    // Operands
    assign unit_op = issue_op;
    assign unit_a = reg_pending[issue_rs1] ? rf.rs1_data : regs[issue_rs1];
    assign unit_b = reg_pending[issue_rs2] ? rf.rs2_data : regs[issue_rs2];
    assign unit_id = ti.issue_id;

    //////////////////////////////////////////////////////////////////////
    // Register state
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_en <= 1'b0;
            reg_pending <= '0;
            for (int i = 0; i < `WB_NUM_REGS; i++)
                regs[i] <= '0;
        end else begin
            issue_en <= 1'b1;
            // Register 0 stays zero
            if (rf.retiring && rf.rd_nzero) begin
                regs[rf.rd_addr] <= rf.rd_data;
                if (reg_writer[rf.rd_addr] == rf.retire_id)
                    reg_pending[rf.rd_addr] <= 1'b0;
            end
            // New issue wins over same-cycle clear
            if (accept && issue_rd != '0)
                reg_pending[issue_rd] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && issue_rd != '0)
            reg_writer[issue_rd] <= ti.issue_id;
    end

endmodule

`default_nettype wire

// ==== src/commit_top.sv ====
// Back end top level
`timescale 1ns/10ps
`default_nettype none
`include "wb_consts.svh"

module commit_top (
    input logic clk,
    input logic rst,
    input logic issue_valid,
    input exec_pkg::exec_op_t issue_op,
    input commit_pkg::reg_addr_t issue_rd,
    input commit_pkg::reg_addr_t issue_rs1,
    input commit_pkg::reg_addr_t issue_rs2,
    output logic issue_ready,
    output logic commit_valid,
    output commit_pkg::instr_id_t commit_id,
    output commit_pkg::reg_addr_t commit_rd,
    output logic [`WB_XLEN-1:0] commit_data,
    output logic queue_empty
);
    tracking_if ti ();
    rf_commit_if rf ();

    // Unit records by unit index
    commit_pkg::unit_wb_t unit_wb [`WB_NUM_UNITS-1:0];
    logic [`WB_NUM_UNITS-1:0] unit_start;
    exec_pkg::exec_op_t unit_op;
    logic [`WB_XLEN-1:0] unit_a;
    logic [`WB_XLEN-1:0] unit_b;
    commit_pkg::instr_id_t unit_id;
    logic shift_busy;

    reg_scoreboard sb0 (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_rd(issue_rd), .issue_rs1(issue_rs1), .issue_rs2(issue_rs2),
        .issue_ready(issue_ready), .shift_busy(shift_busy),
        .unit_start(unit_start), .unit_op(unit_op),
        .unit_a(unit_a), .unit_b(unit_b), .unit_id(unit_id),
        .ti(ti.scoreboard), .rf(rf.scoreboard)
    );

    //////////////////////////////////////////////////////////////////////
    // Execution units
    alu_unit alu0 (
        .clk(clk), .rst(rst), .start(unit_start[exec_pkg::unit_alu]),
        .op(unit_op), .a(unit_a), .b(unit_b), .id(unit_id),
        .wb(unit_wb[exec_pkg::unit_alu])
    );

    shift_unit shift0 (
        .clk(clk), .rst(rst), .start(unit_start[exec_pkg::unit_shift]),
        .op(unit_op), .a(unit_a), .b(unit_b), .id(unit_id),
        .busy(shift_busy), .wb(unit_wb[exec_pkg::unit_shift])
    );

    write_back wb0 (
        .clk(clk), .rst(rst), .unit_wb(unit_wb),
        .ti(ti.wb), .rf(rf.wb), .queue_empty(queue_empty)
    );

    // Commit outputs off the retire port
    assign commit_valid = rf.retiring;
    assign commit_id = rf.retire_id;
    assign commit_rd = rf.rd_addr;
    assign commit_data = rf.rd_data;

endmodule

`default_nettype wire

// ==== verification/commit_assertions.sv ====
// Writeback protocol assertions
`timescale 1ns/10ps
`default_nettype none
`include "wb_consts.svh"

module commit_assertions (
    input logic clk,
    input logic rst,
    input logic retiring_next,
    input logic retiring,
    input commit_pkg::instr_id_t id_retiring,
    input logic queue_empty,
    input logic id_available,
    input logic issued,
    input logic [`WB_MAX_INFLIGHT-1:0] id_writing,
    input logic [`WB_MAX_INFLIGHT-1:0] id_inuse
);
    localparam int CNT_W = $clog2(`WB_MAX_INFLIGHT) + 1;

    int fail_count = 0;
    commit_pkg::instr_id_t expect_retire_id;
    // Own count of IDs in flight
    logic [CNT_W-1:0] occupancy;

    always_ff @(posedge clk) begin
        if (rst) begin
            expect_retire_id <= '0;
            occupancy <= '0;
        end else begin
            if (retiring)
                expect_retire_id <= id_retiring + 1'b1;
            occupancy <= occupancy + CNT_W'(issued) - CNT_W'(retiring_next);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Retire only with something in flight
    retire_not_empty: assert property (@(posedge clk) disable iff (rst)
        retiring_next |-> !queue_empty)
    else begin
        $error("retire decided with no ID in flight");
        fail_count++;
    end

    // Strict ID order, wrapping
    retire_in_order: assert property (@(posedge clk) disable iff (rst)
        retiring |-> (id_retiring == expect_retire_id))
    else begin
        $error("retired ID out of sequence");
        fail_count++;
    end

    full_blocks_alloc: assert property (@(posedge clk) disable iff (rst)
        (occupancy == CNT_W'(`WB_MAX_INFLIGHT)) |-> !id_available)
    else begin
        $error("ID offered while all IDs in flight");
        fail_count++;
    end

    // Buffer writes only to issued, unfinished IDs
    write_to_used_id: assert property (@(posedge clk) disable iff (rst)
        (id_writing & ~id_inuse) == '0)
    else begin
        $error("result written to an ID not in use");
        fail_count++;
    end

endmodule

bind write_back commit_assertions wb_checks0 (
    .clk(clk), .rst(rst),
    .retiring_next(retiring_next), .retiring(retiring),
    .id_retiring(id_retiring), .queue_empty(queue_empty),
    .id_available(ti.id_available), .issued(ti.issued),
    .id_writing(id_writing), .id_inuse(id_inuse)
);

`default_nettype wire

// ==== verification/commit_tb.sv ====
// Writeback back end testbench
`timescale 1ns/10ps
`default_nettype none
`include "wb_consts.svh"

module commit_tb;
    localparam int NUM_INSTR = 200;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 40 + 100;
    localparam int XLEN = `WB_XLEN;

    // Starts low with no edge at time zero
    logic clk = 1'b0;
    logic rst;
    logic issue_valid;
    exec_pkg::exec_op_t issue_op;
    commit_pkg::reg_addr_t issue_rd;
    commit_pkg::reg_addr_t issue_rs1;
    commit_pkg::reg_addr_t issue_rs2;
    logic issue_ready;
    logic commit_valid;
    commit_pkg::instr_id_t commit_id;
    commit_pkg::reg_addr_t commit_rd;
    logic [XLEN-1:0] commit_data;
    logic queue_empty;

    // Program with one entry per instruction
    exec_pkg::exec_op_t prog_op [NUM_INSTR];
    commit_pkg::reg_addr_t prog_rd [NUM_INSTR];
    commit_pkg::reg_addr_t prog_rs1 [NUM_INSTR];
    commit_pkg::reg_addr_t prog_rs2 [NUM_INSTR];
    logic prog_gap [NUM_INSTR];

    // Reference register model and expected commits
    logic [XLEN-1:0] model_regs [`WB_NUM_REGS];
    commit_pkg::instr_id_t model_next_id;
    commit_pkg::instr_id_t exp_id_q [$];
    commit_pkg::reg_addr_t exp_rd_q [$];
    logic [XLEN-1:0] exp_data_q [$];

    int value_errors;
    int flow_errors;
    int assertion_failures;
    int accepted_count;
    int commit_count;
    int cycle_count;
    logic accepted_now;

    commit_top dut0 (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_rd(issue_rd), .issue_rs1(issue_rs1), .issue_rs2(issue_rs2),
        .issue_ready(issue_ready), .commit_valid(commit_valid),
        .commit_id(commit_id), .commit_rd(commit_rd),
        .commit_data(commit_data), .queue_empty(queue_empty)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference rules
    function automatic logic [XLEN-1:0] expected_result(exec_pkg::exec_op_t op,
                                                        logic [XLEN-1:0] a,
                                                        logic [XLEN-1:0] b);
        case (op)
            exec_pkg::op_add: return a + b;
            exec_pkg::op_sub: return a - b;
            exec_pkg::op_xor: return a ^ b;
            exec_pkg::op_and: return a & b;
            // Shift amount is the low five bits of b
            exec_pkg::op_sll: return a << b[4:0];
            exec_pkg::op_srl: return a >> b[4:0];
            default: return '0;
        endcase
    endfunction

    task automatic report_mismatch(string name, logic [XLEN-1:0] expected,
                                   logic [XLEN-1:0] actual);
        $display("error %0t %s expected %0h got %0h", $time, name, expected, actual);
        value_errors++;
    endtask

    // Program order model run on the accept cycle
    task automatic model_accept();
        logic [XLEN-1:0] result;
        result = expected_result(issue_op, model_regs[issue_rs1], model_regs[issue_rs2]);
        exp_id_q.push_back(model_next_id);
        exp_rd_q.push_back(issue_rd);
        exp_data_q.push_back(result);
        // r0 reads as zero forever
        if (issue_rd != '0)
            model_regs[issue_rd] = result;
        model_next_id = model_next_id + 1'b1;
        accepted_count++;
    endtask

    task automatic check_commit();
        commit_pkg::instr_id_t exp_id;
        commit_pkg::reg_addr_t exp_rd;
        logic [XLEN-1:0] exp_data;
        if (exp_id_q.size() == 0) begin
            $display("commit at %0t with no accepted instruction outstanding", $time);
            flow_errors++;
        end else begin
            exp_id = exp_id_q.pop_front();
            exp_rd = exp_rd_q.pop_front();
            exp_data = exp_data_q.pop_front();
            assert (commit_id == exp_id)
                else report_mismatch("commit_id", XLEN'(exp_id), XLEN'(commit_id));
            assert (commit_rd == exp_rd)
                else report_mismatch("commit_rd", XLEN'(exp_rd), XLEN'(commit_rd));
            assert (commit_data == exp_data)
                else report_mismatch("commit_data", exp_data, commit_data);
        end
        commit_count++;
    endtask

    task automatic check_idle();
        assert (commit_valid == 1'b0)
            else report_mismatch("commit_valid", XLEN'(0), XLEN'(commit_valid));
        assert (queue_empty == 1'b1)
            else report_mismatch("queue_empty", XLEN'(1), XLEN'(queue_empty));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Program build from directed sections then biased random
    task automatic build_program();
        commit_pkg::reg_addr_t recent [3];
        int pick;
        for (int k = 0; k < 3; k++)
            recent[k] = commit_pkg::reg_addr_t'(k + 1);
        for (int i = 0; i < NUM_INSTR; i++) begin
            prog_gap[i] = 1'b0;
            prog_op[i] = exec_pkg::exec_op_t'(3'($urandom_range(0, 5)));
            prog_rd[i] = commit_pkg::reg_addr_t'($urandom_range(1, `WB_NUM_REGS - 1));
            prog_rs1[i] = commit_pkg::reg_addr_t'($urandom_range(0, `WB_NUM_REGS - 1));
            prog_rs2[i] = commit_pkg::reg_addr_t'($urandom_range(0, `WB_NUM_REGS - 1));
            if (i < 20) begin
                // Dependent chain where each one reads the last result
                prog_op[i] = (i % 2 == 0) ? exec_pkg::op_add : exec_pkg::op_xor;
                prog_rd[i] = commit_pkg::reg_addr_t'(i % 3 + 1);
                prog_rs1[i] = (i == 0) ? commit_pkg::reg_addr_t'(0) : prog_rd[i - 1];
                prog_rs2[i] = prog_rs1[i];
            end else if (i < 40) begin
                // A shift then ALU ops that finish first
                if (i % 4 == 0)
                    prog_op[i] = (i % 8 == 0) ? exec_pkg::op_sll : exec_pkg::op_srl;
                else
                    prog_op[i] = exec_pkg::exec_op_t'(3'($urandom_range(0, 3)));
            end else if (i < 56) begin
                // r0 as target and later as source
                if (i % 2 == 0)
                    prog_rd[i] = '0;
                prog_rs1[i] = '0;
            end else begin
                pick = int'($urandom_range(0, 3));
                if (pick < 3)
                    prog_rd[i] = recent[pick];
                prog_rs1[i] = recent[$urandom_range(0, 2)];
                prog_gap[i] = ($urandom_range(0, 7) == 0);
            end
            recent[2] = recent[1];
            recent[1] = recent[0];
            recent[0] = prog_rd[i];
        end
    endtask

    task automatic drive_instr(int idx);
        issue_valid = 1'b1;
        issue_op = prog_op[idx];
        issue_rd = prog_rd[idx];
        issue_rs1 = prog_rs1[idx];
        issue_rs2 = prog_rs2[idx];
    endtask

    //////////////////////////////////////////////////////////////////////
    // Monitor at mid-cycle where inputs and registered outputs are settled
    always @(negedge clk) begin
        if (rst) begin
            accepted_now = 1'b0;
            check_idle();
            assert (issue_ready == 1'b0)
                else report_mismatch("issue_ready", XLEN'(0), XLEN'(issue_ready));
        end else begin
            accepted_now = issue_valid && issue_ready;
            if (accepted_now)
                model_accept();
            if (commit_valid)
                check_commit();
            // Counts include the accept about to happen
            assert (accepted_count - commit_count <= `WB_MAX_INFLIGHT) else begin
                $display("more than %0d instructions outstanding at %0t",
                         `WB_MAX_INFLIGHT, $time);
                flow_errors++;
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d instructions committed",
                     cycle_count, commit_count, NUM_INSTR);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        void'($urandom(32'h51275696));
        rst = 1'b1;
        issue_valid = 1'b0;
        issue_op = exec_pkg::op_add;
        issue_rd = '0;
        issue_rs1 = '0;
        issue_rs2 = '0;
        value_errors = 0;
        flow_errors = 0;
        accepted_count = 0;
        commit_count = 0;
        accepted_now = 1'b0;
        model_next_id = '0;
        for (int k = 0; k < `WB_NUM_REGS; k++)
            model_regs[k] = '0;
        build_program();

        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        // Nothing in flight just after reset
        @(negedge clk);
        check_idle();
        @(posedge clk);

        for (int i = 0; i < NUM_INSTR; i++) begin
            if (prog_gap[i]) begin
                #1 issue_valid = 1'b0;
                @(posedge clk);
            end
            #1 drive_instr(i);
            @(posedge clk);
            while (!accepted_now)
                @(posedge clk);
        end
        #1 issue_valid = 1'b0;

        // Drain
        while (!queue_empty) begin
            @(posedge clk);
            #1;
        end
        repeat (3) @(posedge clk);

        assertion_failures = dut0.wb0.wb_checks0.fail_count;
        assert (commit_count == accepted_count && accepted_count == NUM_INSTR) else begin
            $display("%0d commits for %0d accepted of %0d instructions",
                     commit_count, accepted_count, NUM_INSTR);
            flow_errors++;
        end
        assert (queue_empty == 1'b1)
            else report_mismatch("queue_empty", XLEN'(1), XLEN'(queue_empty));

        $display("run summary: %0d value errors, %0d flow errors, %0d assertion failures",
                 value_errors, flow_errors, assertion_failures);
        if (value_errors + flow_errors + assertion_failures == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
src/commit_pkg.sv
src/exec_pkg.sv
src/wb_ifs.sv
src/id_tracker.sv
src/write_back.sv
src/alu_unit.sv
src/shift_unit.sv
src/reg_scoreboard.sv
src/commit_top.sv
verification/commit_assertions.sv
verification/commit_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = commit_tb
FILELIST = filelist.f
OBJ_DIR = obj_dir
RUN_ARGS = +verilator+error+limit+1000
PASS_MSG = ALL CHECKS PASSED

SIM = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$($(SIM) $(RUN_ARGS))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
